// File: ddr_link_tx.f
logic/ddr_link_pkg.sv
logic/link_piso.sv
logic/link_credit_ctrl.sv
logic/link_source_sync.sv
logic/link_oddr_phy.sv
logic/ddr_link_upstream.sv
verification/ddr_link_upstream_assert.sv
verification/ddr_link_upstream_tb.sv

// File: logic/ddr_link_pkg.sv
package ddr_link_pkg;

  // Pad bits per channel, one byte per PHY edge
  localparam int CHANNEL_WIDTH = 8;
  // One channel word covers both edges of the forwarded clock
  localparam int DDR_WIDTH = 2 * CHANNEL_WIDTH;
  localparam int NUM_CHANNELS = 2;
  localparam int CORE_WIDTH = 64;

  // Bits handed to all channels on one serializer beat
  localparam int SLICE_WIDTH = DDR_WIDTH * NUM_CHANNELS;
  // Number of beats needed per core word
  localparam int POSI_RATIO = CORE_WIDTH / SLICE_WIDTH;
  localparam int SLICE_IDX_WIDTH = (POSI_RATIO > 1) ? $clog2(POSI_RATIO) : 1;

  // Output FIFO per channel; its depth is also the starting credit count
  localparam int LG_FIFO_DEPTH = 3;
  localparam int FIFO_DEPTH = 1 << LG_FIFO_DEPTH;

  // One token edge from the receiver stands for this many consumed words
  localparam int LG_TOKEN_DECIMATION = 1;
  localparam int TOKEN_CREDITS = 1 << LG_TOKEN_DECIMATION;

  // Extra bit so a full count of FIFO_DEPTH fits
  localparam int CREDIT_WIDTH = LG_FIFO_DEPTH + 1;

  // What one PHY edge carries on the pads
  typedef struct packed {
    logic                     valid;
    logic [CHANNEL_WIDTH-1:0] data;
  } ddr_byte_t;

  // One channel word, lo byte goes out first
  typedef struct packed {
    logic [CHANNEL_WIDTH-1:0] hi;
    logic [CHANNEL_WIDTH-1:0] lo;
  } lane_word_t;

  // Serializer holds either nothing or one core word being cut into slices
  typedef enum logic {
    PISO_EMPTY,
    PISO_SHIFTING
  } piso_state_e;

  // Which half of the DDR word is on the pads, also the forwarded clock level
  typedef enum logic {
    PHASE_LO,
    PHASE_HI
  } phy_phase_e;

endpackage

// File: logic/ddr_link_upstream.sv
`timescale 1ns/1ps

module ddr_link_upstream (
  input  logic                                 core_clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 link_enable_i,
  input  logic                                 core_valid_i,
  input  logic [ddr_link_pkg::CORE_WIDTH-1:0]  core_data_i,
  output logic                                 core_ready_o,
  output logic [ddr_link_pkg::NUM_CHANNELS-1:0] io_clk_r_o,
  output logic [ddr_link_pkg::NUM_CHANNELS-1:0][ddr_link_pkg::CHANNEL_WIDTH-1:0] io_data_r_o,
  output logic [ddr_link_pkg::NUM_CHANNELS-1:0] io_valid_r_o,
  input  logic [ddr_link_pkg::NUM_CHANNELS-1:0] io_token_i
);

  import ddr_link_pkg::*;

  logic                               slice_valid;
  logic                               slice_yumi;
  lane_word_t [NUM_CHANNELS-1:0]      slice_data;
  logic [NUM_CHANNELS-1:0]            lane_ready;

  // All channels take a slice together, so one full FIFO stalls the serializer
  assign slice_yumi = (&lane_ready) && slice_valid;

  link_piso u_piso (
    .core_clk_i    (core_clk_i),
    .rst_n_i       (rst_n_i),
    .core_valid_i  (core_valid_i),
    .core_data_i   (core_data_i),
    .core_ready_o  (core_ready_o),
    .slice_valid_o (slice_valid),
    .slice_data_o  (slice_data),
    .slice_yumi_i  (slice_yumi)
  );

  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_lane
    logic       phy_valid;
    logic       phy_ready;
    lane_word_t phy_data;
    ddr_byte_t  pad;

    // Credit gated FIFO for this channel
    link_source_sync u_sso (
      .core_clk_i    (core_clk_i),
      .rst_n_i       (rst_n_i),
      .link_enable_i (link_enable_i),
      .lane_valid_i  (slice_yumi),
      .lane_data_i   (slice_data[ch]),
      .lane_ready_o  (lane_ready[ch]),
      .token_i       (io_token_i[ch]),
      .phy_valid_o   (phy_valid),
      .phy_data_o    (phy_data),
      .phy_ready_i   (phy_ready)
    );

    link_oddr_phy u_phy (
      .core_clk_i    (core_clk_i),
      .rst_n_i       (rst_n_i),
      .link_enable_i (link_enable_i),
      .phy_valid_i   (phy_valid),
      .phy_data_i    (phy_data),
      .phy_ready_o   (phy_ready),
      .io_clk_r_o    (io_clk_r_o[ch]),
      .io_pad_r_o    (pad)
    );

    // Pad byte split into data and valid pins
    assign io_data_r_o[ch]  = pad.data;
    assign io_valid_r_o[ch] = pad.valid;
  end

endmodule

// File: logic/link_credit_ctrl.sv
`timescale 1ns/1ps

module link_credit_ctrl (
  input  logic core_clk_i,
  input  logic rst_n_i,
  input  logic token_i,
  input  logic send_i,
  output logic has_credit_o
);

  import ddr_link_pkg::*;

  // Token line from the receiver, sampled then delayed once more
  logic token_r;
  logic token_prev_r;
  logic token_edge;

  // Words the receiver can still absorb
  logic [CREDIT_WIDTH-1:0] credit_cnt_r;
  logic [CREDIT_WIDTH-1:0] credit_cnt_n;

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      token_r      <= 1'b0;
      token_prev_r <= 1'b0;
    end else begin
      token_r      <= token_i;
      token_prev_r <= token_r;
    end
  end

  // Receiver toggles the line, so rising and falling edges both count
  assign token_edge = token_r ^ token_prev_r;

  always_comb begin
    credit_cnt_n = credit_cnt_r;
    // One credit spent per word handed to the PHY
    if (send_i) begin
      credit_cnt_n = credit_cnt_n - CREDIT_WIDTH'(1);
    end
    // Each token edge returns a decimated batch of credits
    if (token_edge) begin
      credit_cnt_n = credit_cnt_n + CREDIT_WIDTH'(TOKEN_CREDITS);
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      // Receiver FIFO starts empty, so the whole depth is available
      credit_cnt_r <= CREDIT_WIDTH'(FIFO_DEPTH);
    end else begin
      credit_cnt_r <= credit_cnt_n;
    end
  end

  // Sending stops as soon as the last credit is used
  assign has_credit_o = (credit_cnt_r != '0);

endmodule

// File: logic/link_oddr_phy.sv
`timescale 1ns/1ps

module link_oddr_phy (
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  input  logic                     link_enable_i,
  input  logic                     phy_valid_i,
  input  ddr_link_pkg::lane_word_t phy_data_i,
  output logic                     phy_ready_o,
  output logic                     io_clk_r_o,
  output ddr_link_pkg::ddr_byte_t  io_pad_r_o
);

  import ddr_link_pkg::*;

  // Phase of the byte now on the pads
  phy_phase_e phase_r;
  phy_phase_e phase_n;

  // Hi byte and its valid, waiting for the second edge
  ddr_byte_t hold_r;
  ddr_byte_t hold_n;

  ddr_byte_t pad_r;
  ddr_byte_t pad_n;

  logic idle;
  logic accept;

  // Disabled with no half word in flight, the phase is parked low
  assign idle = (phase_r == PHASE_LO) && !link_enable_i && !hold_r.valid;

  // New word only after a hi byte, so words stream back to back
  assign phy_ready_o = (phase_r == PHASE_HI) || idle;
  assign accept      = phy_valid_i && phy_ready_o;

  always_comb begin
    phase_n = phase_r;
    hold_n  = hold_r;
    pad_n   = '0;
    if (accept) begin
      // Lo byte goes out next cycle with the clock low
      phase_n      = PHASE_LO;
      pad_n        = '{valid: 1'b1, data: phy_data_i.lo};
      hold_n       = '{valid: 1'b1, data: phy_data_i.hi};
    end else if (phase_r == PHASE_HI) begin
      // End of a word or an empty slot, pads go quiet
      phase_n      = PHASE_LO;
      hold_n.valid = 1'b0;
    end else if (link_enable_i || hold_r.valid) begin
      // Finish the word even if the link was just disabled
      phase_n = PHASE_HI;
      pad_n   = hold_r;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      phase_r <= PHASE_LO;
      hold_r  <= '0;
      pad_r   <= '0;
    end else begin
      phase_r <= phase_n;
      hold_r  <= hold_n;
      pad_r   <= pad_n;
    end
  end

  // Forwarded clock is high exactly while the hi byte is out
  assign io_clk_r_o = (phase_r == PHASE_HI);
  assign io_pad_r_o = pad_r;

endmodule

// File: logic/link_piso.sv
`timescale 1ns/1ps

module link_piso (
  input  logic                                                  core_clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  core_valid_i,
  input  logic [ddr_link_pkg::CORE_WIDTH-1:0]                   core_data_i,
  output logic                                                  core_ready_o,
  output logic                                                  slice_valid_o,
  output ddr_link_pkg::lane_word_t [ddr_link_pkg::NUM_CHANNELS-1:0] slice_data_o,
  input  logic                                                  slice_yumi_i
);

  import ddr_link_pkg::*;

  piso_state_e state_r;

  // Core word stored as an array of slices, slice 0 in the low bits
  logic [POSI_RATIO-1:0][SLICE_WIDTH-1:0] word_r;

  // Slice currently presented to the senders
  logic [SLICE_IDX_WIDTH-1:0] idx_r;

  logic last_slice;
  logic core_take;

  // Last slice of the held word is on the output
  assign last_slice = (state_r == PISO_SHIFTING) &&
                      (idx_r == SLICE_IDX_WIDTH'(POSI_RATIO - 1));

  // Ready when empty, or when the last slice leaves on this edge
  // so a new word loads without a bubble
  assign core_ready_o = (state_r == PISO_EMPTY) || (last_slice && slice_yumi_i);
  assign core_take    = core_valid_i && core_ready_o;

  assign slice_valid_o = (state_r == PISO_SHIFTING);

  // Each slice splits into one lane_word_t per channel, channel 0 lowest
  assign slice_data_o = word_r[idx_r];

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      state_r <= PISO_EMPTY;
      idx_r   <= '0;
    end else if (core_take) begin
      // Fresh word starts from slice 0
      state_r <= PISO_SHIFTING;
      idx_r   <= '0;
    end else if (slice_yumi_i) begin
      if (last_slice) begin
        // Nothing waiting on the core side
        state_r <= PISO_EMPTY;
        idx_r   <= '0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  // Payload register, loaded only on acceptance
  always_ff @(posedge core_clk_i) begin
    if (core_take) begin
      word_r <= core_data_i;
    end
  end

endmodule

// File: logic/link_source_sync.sv
`timescale 1ns/1ps

module link_source_sync (
  input  logic                     core_clk_i,
  input  logic                     rst_n_i,
  input  logic                     link_enable_i,
  input  logic                     lane_valid_i,
  input  ddr_link_pkg::lane_word_t lane_data_i,
  output logic                     lane_ready_o,
  input  logic                     token_i,
  output logic                     phy_valid_o,
  output ddr_link_pkg::lane_word_t phy_data_o,
  input  logic                     phy_ready_i
);

  import ddr_link_pkg::*;

  // Circular buffer of lane words
  lane_word_t mem_r [FIFO_DEPTH];

  // Pointers carry one wrap bit above the address
  logic [LG_FIFO_DEPTH:0] wr_ptr_r;
  logic [LG_FIFO_DEPTH:0] rd_ptr_r;

  logic fifo_empty;
  logic fifo_full;
  logic push;
  logic pop;
  logic has_credit;

  assign fifo_empty = (wr_ptr_r == rd_ptr_r);
  // Same address on opposite laps
  assign fifo_full  = (wr_ptr_r[LG_FIFO_DEPTH] != rd_ptr_r[LG_FIFO_DEPTH]) &&
                      (wr_ptr_r[LG_FIFO_DEPTH-1:0] == rd_ptr_r[LG_FIFO_DEPTH-1:0]);

  assign lane_ready_o = !fifo_full;
  assign push         = lane_valid_i && !fifo_full;

  // Send needs data, a credit and an enabled link
  assign phy_valid_o = !fifo_empty && has_credit && link_enable_i;
  assign phy_data_o  = mem_r[rd_ptr_r[LG_FIFO_DEPTH-1:0]];
  assign pop         = phy_valid_o && phy_ready_i;

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r[LG_FIFO_DEPTH-1:0]] <= lane_data_i;
    end
  end

  // Every word popped toward the pads spends one credit
  link_credit_ctrl u_credit (
    .core_clk_i   (core_clk_i),
    .rst_n_i      (rst_n_i),
    .token_i      (token_i),
    .send_i       (pop),
    .has_credit_o (has_credit)
  );

endmodule

// File: verification/ddr_link_upstream_assert.sv
`timescale 1ns/1ps

module ddr_link_upstream_assert #(
  // Selects the PHY rules or the credit rule for this instance
  parameter bit CHECK_PHY = 1'b1
) (
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input logic                                  link_enable_i,
  input logic                                  io_clk_i,
  input logic                                  pad_valid_i,
  input logic [ddr_link_pkg::CREDIT_WIDTH-1:0] credit_cnt_i
);

  import ddr_link_pkg::*;

  // Failed assertions in this instance
  int fail_cnt = 0;

  // A valid lo byte is always followed by its valid hi byte
  a_lo_then_hi: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (CHECK_PHY && pad_valid_i && !io_clk_i) |=> (pad_valid_i && io_clk_i))
    else begin
      $error("Valid lo byte not followed by a valid hi byte");
      fail_cnt++;
    end

  // And a valid hi byte never shows up without its lo byte
  a_hi_after_lo: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (CHECK_PHY && pad_valid_i && io_clk_i) |-> $past(pad_valid_i && !io_clk_i))
    else begin
      $error("Valid hi byte without a preceding valid lo byte");
      fail_cnt++;
    end

  // Forwarded clock toggles on every cycle of an enabled link
  a_clk_toggles: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (CHECK_PHY && link_enable_i) |=> (io_clk_i != $past(io_clk_i)))
    else begin
      $error("Forwarded clock did not toggle while the link was enabled");
      fail_cnt++;
    end

  // Credits never go above the receiver FIFO depth
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !CHECK_PHY |-> (credit_cnt_i <= CREDIT_WIDTH'(FIFO_DEPTH)))
    else begin
      $error("Credit count above FIFO depth");
      fail_cnt++;
    end

endmodule

bind link_oddr_phy ddr_link_upstream_assert #(.CHECK_PHY(1'b1)) u_assert (
  .clk_i         (core_clk_i),
  .rst_n_i       (rst_n_i),
  .link_enable_i (link_enable_i),
  .io_clk_i      (io_clk_r_o),
  .pad_valid_i   (io_pad_r_o.valid),
  .credit_cnt_i  ('0)
);

bind link_credit_ctrl ddr_link_upstream_assert #(.CHECK_PHY(1'b0)) u_assert (
  .clk_i         (core_clk_i),
  .rst_n_i       (rst_n_i),
  .link_enable_i (1'b0),
  .io_clk_i      (1'b0),
  .pad_valid_i   (1'b0),
  .credit_cnt_i  (credit_cnt_r)
);

// File: verification/ddr_link_upstream_tb.sv
`timescale 1ns/1ps

module ddr_link_upstream_tb;

  import ddr_link_pkg::*;

  localparam int SLICES = 2;
  localparam int RANDOM_WORDS = 40;
  // Random run, credit stall run, disabled link run and one pattern word
  localparam int TOTAL_WORDS = RANDOM_WORDS + 10 + 4 + 1;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_WORDS * 4;
  localparam int MEM_DEPTH = 256;
  localparam int DRAIN_LIMIT = 300;

  logic                                        core_clk;
  logic                                        rst_n;
  logic                                        link_enable;
  logic                                        core_valid;
  logic [63:0]                                 core_data;
  logic                                        core_ready;
  logic [NUM_CHANNELS-1:0]                     io_clk;
  logic [NUM_CHANNELS-1:0][CHANNEL_WIDTH-1:0]  io_data;
  logic [NUM_CHANNELS-1:0]                     io_valid;
  logic [NUM_CHANNELS-1:0]                     io_token;

  // Expected and received words with one column per channel
  logic [15:0] exp_mem [NUM_CHANNELS][MEM_DEPTH];
  logic [15:0] rx_mem  [NUM_CHANNELS][MEM_DEPTH];
  int          exp_cnt = 0;
  int          rx_cnt  [NUM_CHANNELS] = '{default: 0};
  int          chk_cnt [NUM_CHANNELS] = '{default: 0};
  int          tok_cnt [NUM_CHANNELS] = '{default: 0};
  logic [7:0]  lo_byte [NUM_CHANNELS];
  logic        lo_seen [NUM_CHANNELS] = '{default: 1'b0};

  logic   token_en;
  logic   quiet_check;
  logic   sender_done;
  integer seed;
  int     error_count = 0;

  ddr_link_upstream uut (
    .core_clk_i    (core_clk),
    .rst_n_i       (rst_n),
    .link_enable_i (link_enable),
    .core_valid_i  (core_valid),
    .core_data_i   (core_data),
    .core_ready_o  (core_ready),
    .io_clk_r_o    (io_clk),
    .io_data_r_o   (io_data),
    .io_valid_r_o  (io_valid),
    .io_token_i    (io_token)
  );

  initial begin
    core_clk = 1'b0;
    forever #5 core_clk = ~core_clk;
  end

  // Slice s is core bits [32s+31:32s] and channel c takes 16-bit field c of it
  function automatic logic [15:0] expected_lane_word(input logic [63:0] word,
                                                     input int slice, input int ch);
    return word[32*slice + 16*ch +: 16];
  endfunction

  // Record expected words at every accepted core word
  always @(posedge core_clk) begin
    if (rst_n && core_valid && core_ready) begin
      for (int s = 0; s < SLICES; s++) begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
          exp_mem[c][exp_cnt] = expected_lane_word(core_data, s, c);
        end
        exp_cnt++;
      end
    end
  end

  // Receiver model takes the lo byte with clock low and then the hi byte with clock high
  always @(posedge core_clk) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (io_valid[c] && !io_clk[c]) begin
        lo_byte[c] = io_data[c];
        lo_seen[c] = 1'b1;
      end else if (io_valid[c] && io_clk[c]) begin
        if (!lo_seen[c]) begin
          $display("Channel %0d sent a hi byte with no lo byte before it", c);
          error_count++;
        end
        rx_mem[c][rx_cnt[c]] = {io_data[c], lo_byte[c]};
        rx_cnt[c]++;
        lo_seen[c] = 1'b0;
      end
    end
  end

  // Token model toggles once per two words consumed
  initial begin
    io_token = '0;
    forever begin
      @(negedge core_clk);
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        if (token_en && (rx_cnt[c] - 2 * tok_cnt[c] >= 2)) begin
          io_token[c] = ~io_token[c];
          tok_cnt[c]++;
        end
      end
    end
  end

  // Compare every received word in order
  always @(negedge core_clk) begin
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      while (chk_cnt[c] < rx_cnt[c]) begin
        if (chk_cnt[c] >= exp_cnt) begin
          $display("Channel %0d delivered a word that was never sent", c);
          error_count++;
        end else if (rx_mem[c][chk_cnt[c]] !== exp_mem[c][chk_cnt[c]]) begin
          $display("[ERROR] %0t: channel %0d word %0d is %h, expected %h", $time, c,
                   chk_cnt[c], rx_mem[c][chk_cnt[c]], exp_mem[c][chk_cnt[c]]);
          error_count++;
        end
        chk_cnt[c]++;
      end
    end
  end

  // Pads must stay quiet while the link is off
  always @(negedge core_clk) begin
    if (quiet_check && (io_valid !== '0 || io_clk !== '0)) begin
      $display("[ERROR] %0t: link disabled but valid=%b clk=%b", $time, io_valid, io_clk);
      error_count++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge core_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // Called on a falling edge and returns on one after acceptance and gap
  task automatic send_word(input logic [63:0] word, input int gap);
    core_valid = 1'b1;
    core_data  = word;
    @(posedge core_clk);
    while (!core_ready) begin
      @(posedge core_clk);
    end
    @(negedge core_clk);
    core_valid = 1'b0;
    repeat (gap) @(negedge core_clk);
  endtask

  task automatic wait_drained();
    int  cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < DRAIN_LIMIT) begin
      @(negedge core_clk);
      cycles++;
      done = 1'b1;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
        if (rx_cnt[c] != exp_cnt) begin
          done = 1'b0;
        end
      end
    end
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (rx_cnt[c] != exp_cnt) begin
        $display("Channel %0d is missing %0d words after the drain wait", c,
                 exp_cnt - rx_cnt[c]);
        error_count++;
      end
    end
    // Let the last tokens come back as credits
    repeat (8) @(negedge core_clk);
  endtask

  task automatic check_slice_word(input int ch, input int idx, input logic [15:0] expected);
    if (rx_mem[ch][idx] !== expected) begin
      $display("[ERROR] %0t: channel %0d word %0d is %h, pattern needs %h", $time, ch, idx,
               rx_mem[ch][idx], expected);
      error_count++;
    end
  endtask

  initial begin
    int base [NUM_CHANNELS];
    int base_idx;
    int assert_failures;
    rst_n       = 1'b0;
    link_enable = 1'b0;
    core_valid  = 1'b0;
    core_data   = '0;
    token_en    = 1'b1;
    quiet_check = 1'b0;
    sender_done = 1'b0;
    seed        = 32'h936d;
    repeat (2) @(posedge core_clk);
    @(negedge core_clk);
    rst_n = 1'b1;

    // Reset values with the link still off
    repeat (10) begin
      @(negedge core_clk);
      if (core_ready !== 1'b1 || io_valid !== '0 || io_clk !== '0 || io_data !== '0) begin
        $display("[ERROR] %0t: after reset ready=%b valid=%b clk=%b data=%h", $time,
                 core_ready, io_valid, io_clk, io_data);
        error_count++;
      end
    end

    // Random words with random gaps while tokens flow
    link_enable = 1'b1;
    for (int i = 0; i < RANDOM_WORDS; i++) begin
      send_word({$random(seed), $random(seed)}, $random(seed) & 3);
    end
    wait_drained();

    // Without tokens only the initial 8 credits worth of words go out
    token_en = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      base[c] = rx_cnt[c];
    end
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          send_word({$random(seed), $random(seed)}, 0);
        end
        sender_done = 1'b1;
      end
    join_none
    repeat (100) @(negedge core_clk);
    if (core_ready !== 1'b0) begin
      $display("Core port still accepts words although both lanes are out of credits");
      error_count++;
    end
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (rx_cnt[c] - base[c] != 8) begin
        $display("[ERROR] %0t: channel %0d sent %0d words without tokens, expected 8",
                 $time, c, rx_cnt[c] - base[c]);
        error_count++;
      end
    end
    token_en = 1'b1;
    wait (sender_done);
    wait_drained();

    // Words queued behind a disabled link
    link_enable = 1'b0;
    repeat (2) @(negedge core_clk);
    quiet_check = 1'b1;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      base[c] = rx_cnt[c];
    end
    for (int i = 0; i < 4; i++) begin
      send_word({$random(seed), $random(seed)}, 0);
    end
    repeat (20) @(negedge core_clk);
    quiet_check = 1'b0;
    for (int c = 0; c < NUM_CHANNELS; c++) begin
      if (rx_cnt[c] != base[c]) begin
        $display("[ERROR] %0t: channel %0d delivered %0d words while disabled", $time, c,
                 rx_cnt[c] - base[c]);
        error_count++;
      end
    end
    link_enable = 1'b1;
    wait_drained();

    // Distinct bytes show which field lands on which channel
    base_idx = exp_cnt;
    send_word(64'h8877_6655_4433_2211, 0);
    wait_drained();
    check_slice_word(0, base_idx, 16'h2211);
    check_slice_word(1, base_idx, 16'h4433);
    check_slice_word(0, base_idx + 1, 16'h6655);
    check_slice_word(1, base_idx + 1, 16'h8877);

    assert_failures = uut.g_lane[0].u_phy.u_assert.fail_cnt +
                      uut.g_lane[1].u_phy.u_assert.fail_cnt +
                      uut.g_lane[0].u_sso.u_credit.u_assert.fail_cnt +
                      uut.g_lane[1].u_sso.u_credit.u_assert.fail_cnt;
    $display("Finished with %0d check errors and %0d assertion failures", error_count,
             assert_failures);
    if (error_count == 0 && assert_failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
